// ==== hdl/ex_consts.svh ====
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath
`define XLEN        32
`define REG_ADDR_W  5

// page translation fields
`define VPPN_W      19  // va[31:13], one entry maps an even/odd page pair
`define PPN_W       20
`define ASID_W      10
`define PAGE_OFS_W  12  // 4 KiB pages

// privilege and memory type
`define PLV_W       2   // 0 is the most privileged level
`define MAT_W       2

// direct mapping windows
`define SEG_W       3
`define SEG_LSB     29  // window segment is va[31:29]

`endif

// ==== hdl/pipe_pkg.sv ====
`include "ex_consts.svh"

package pipe_pkg;

    // memory operation carried down the pipe
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LD_B     = 4'd1,
        LD_BU    = 4'd2,
        LD_H     = 4'd3,
        LD_HU    = 4'd4,
        LD_W     = 4'd5,
        ST_B     = 4'd6,
        ST_H     = 4'd7,
        ST_W     = 4'd8
    } mem_op_e;

    // decode -> execute
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rj_value;
        logic [`XLEN-1:0]       rkd_value;  // store data for st.*
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   gr_we;
        mem_op_e                mem_op;
        logic                   prior_exc;  // fault raised by fetch or decode
    } ds_to_es_t;

    // exceptions found by the memory access in execute
    typedef struct packed {
        logic ale;
        logic tlb_refill;
        logic load_invalid;
        logic store_invalid;
        logic plv_invalid;
        logic store_dirty;
    } mem_exc_t;

    // execute -> memory
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   gr_we;
        mem_op_e                mem_op;
        logic [`XLEN-1:0]       vaddr;      // kept for badv on a fault
        mem_exc_t               exc;
        logic                   prior_exc;
    } es_to_ms_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {ST_B, ST_H, ST_W};
    endfunction

endpackage

// ==== hdl/mmu_pkg.sv ====
`include "ex_consts.svh"

package mmu_pkg;

    // current mode register, translation part only
    //   da=1 pg=0  direct
    //   da=0 pg=1  mapped
    typedef struct packed {
        logic              da;
        logic              pg;
        logic [`PLV_W-1:0] plv;
        logic [`MAT_W-1:0] datm;  // access type for data accesses
    } crmd_t;

    // one direct mapping window
    typedef struct packed {
        logic              plv0;  // usable at level 0
        logic              plv3;  // usable at level 3
        logic [`MAT_W-1:0] mat;
        logic [`SEG_W-1:0] pseg;  // physical segment
        logic [`SEG_W-1:0] vseg;  // virtual segment to match
    } dmw_t;

    // lookup port towards the tlb
    typedef struct packed {
        logic [`VPPN_W-1:0] vppn;
        logic               va_bit12;  // picks the odd or even page
        logic [`ASID_W-1:0] asid;
    } tlb_req_t;

    // lookup answer, same cycle
    typedef struct packed {
        logic               found;
        logic [`PPN_W-1:0]  ppn;
        logic [`PLV_W-1:0]  plv;
        logic               d;  // page dirty, write allowed
        logic               v;  // page valid
    } tlb_resp_t;

endpackage

// ==== hdl/ex_pipe_reg.sv ====
`timescale 1ns/1ps

module ex_pipe_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_ex,
    input  logic                 ds_to_es_valid,
    input  pipe_pkg::ds_to_es_t  ds_to_es_bus,
    input  logic                 ready_go,
    input  logic                 ms_allow_in,
    output logic                 es_valid,
    output logic                 es_allow_in,
    output logic                 es_to_ms_valid,
    output pipe_pkg::ds_to_es_t  es_inst
);

    // empty, or the current item leaves this cycle
    assign es_allow_in = !es_valid || (ready_go && ms_allow_in);

    // a flushed item must not reach memory stage
    assign es_to_ms_valid = es_valid && ready_go && !wb_ex;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (wb_ex) begin
            es_valid <= 1'b0;  // flush wins over a new item
        end else if (es_allow_in) begin
            es_valid <= ds_to_es_valid;
        end
    end

    // payload only, valid bit qualifies it
    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allow_in) begin
            es_inst <= ds_to_es_bus;
        end
    end

endmodule

// ==== hdl/addr_translate.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module addr_translate (
    input  pipe_pkg::ds_to_es_t  es_inst,
    input  mmu_pkg::crmd_t       csr_crmd,
    input  mmu_pkg::dmw_t        dmw0,
    input  mmu_pkg::dmw_t        dmw1,
    input  logic [`ASID_W-1:0]   tlb_asid,
    input  mmu_pkg::tlb_resp_t   tlb_resp,
    output logic [`XLEN-1:0]     vaddr,
    output logic [`XLEN-1:0]     paddr,
    output mmu_pkg::tlb_req_t    tlb_req,
    output pipe_pkg::mem_exc_t   page_exc
);
    import pipe_pkg::*;
    import mmu_pkg::*;

    logic direct_mode;
    logic mapped_mode;
    logic dmw0_hit;
    logic dmw1_hit;
    logic is_ld;
    logic is_st;
    logic page_walk;     // mapped access that falls through to the tlb
    logic page_ok;       // entry present and valid
    logic [`SEG_W-1:0] vseg;

    // window usable at this level, same access type, same segment
    function automatic logic dmw_hit(
        dmw_t              win,
        logic [`PLV_W-1:0] plv,
        logic [`MAT_W-1:0] datm,
        logic [`SEG_W-1:0] seg
    );
        logic plv_ok;
        plv_ok = (plv == 2'd0 && win.plv0) || (plv == 2'd3 && win.plv3);
        return plv_ok && (win.mat == datm) && (win.vseg == seg);
    endfunction

    assign vaddr = es_inst.rj_value + es_inst.imm;
    assign vseg  = vaddr[`XLEN-1:`SEG_LSB];

    assign direct_mode = csr_crmd.da & ~csr_crmd.pg;
    assign mapped_mode = ~csr_crmd.da & csr_crmd.pg;

    assign dmw0_hit = dmw_hit(dmw0, csr_crmd.plv, csr_crmd.datm, vseg);
    assign dmw1_hit = dmw_hit(dmw1, csr_crmd.plv, csr_crmd.datm, vseg);

    assign is_ld = is_load(es_inst.mem_op);
    assign is_st = is_store(es_inst.mem_op);

    assign page_walk = mapped_mode & ~dmw0_hit & ~dmw1_hit & (is_ld | is_st);
    assign page_ok   = tlb_resp.found & tlb_resp.v;

    // lookup is always driven, the tlb answers in the same cycle
    assign tlb_req.vppn     = vaddr[`XLEN-1:`PAGE_OFS_W+1];
    assign tlb_req.va_bit12 = vaddr[`PAGE_OFS_W];
    assign tlb_req.asid     = tlb_asid;

    always_comb begin
        if (direct_mode) begin
            paddr = vaddr;
        end else if (mapped_mode) begin
            if (dmw0_hit) begin  // window 0 has priority
                paddr = {dmw0.pseg, vaddr[`SEG_LSB-1:0]};
            end else if (dmw1_hit) begin
                paddr = {dmw1.pseg, vaddr[`SEG_LSB-1:0]};
            end else begin
                paddr = {tlb_resp.ppn, vaddr[`PAGE_OFS_W-1:0]};
            end
        end else begin
            paddr = '0;  // undefined mode combination
        end
    end

    always_comb begin
        page_exc               = '0;
        page_exc.tlb_refill    = page_walk & ~tlb_resp.found;
        page_exc.load_invalid  = page_walk & is_ld & tlb_resp.found & ~tlb_resp.v;
        page_exc.store_invalid = page_walk & is_st & tlb_resp.found & ~tlb_resp.v;
        // larger plv number means less privilege
        page_exc.plv_invalid   = page_walk & page_ok & (csr_crmd.plv > tlb_resp.plv);
        page_exc.store_dirty   = page_walk & is_st & page_ok & ~tlb_resp.d
                               & (csr_crmd.plv <= tlb_resp.plv);
    end

endmodule

// ==== hdl/mem_access_format.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module mem_access_format (
    input  pipe_pkg::ds_to_es_t  es_inst,
    input  logic [`XLEN-1:0]     vaddr,
    output logic                 data_sram_wr,
    output logic [1:0]           data_sram_size,
    output logic [3:0]           data_sram_wstrb,
    output logic [`XLEN-1:0]     data_sram_wdata,
    output logic                 ale
);
    import pipe_pkg::*;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    logic [1:0] byte_ofs;

    assign byte_ofs     = vaddr[1:0];
    assign data_sram_wr = is_store(es_inst.mem_op);

    always_comb begin
        data_sram_size  = SIZE_BYTE;
        data_sram_wstrb = 4'b0000;  // loads write nothing
        data_sram_wdata = '0;
        ale             = 1'b0;
        case (es_inst.mem_op)
            LD_B, LD_BU: begin
                data_sram_size = SIZE_BYTE;
            end
            LD_H, LD_HU: begin
                data_sram_size = SIZE_HALF;
                ale            = byte_ofs[0];
            end
            LD_W: begin
                data_sram_size = SIZE_WORD;
                ale            = |byte_ofs;
            end
            ST_B: begin
                data_sram_size  = SIZE_BYTE;
                data_sram_wstrb = 4'b0001 << byte_ofs;
                data_sram_wdata = {4{es_inst.rkd_value[7:0]}};
            end
            ST_H: begin
                data_sram_size  = SIZE_HALF;
                data_sram_wstrb = byte_ofs[1] ? 4'b1100 : 4'b0011;  // upper or lower half
                data_sram_wdata = {2{es_inst.rkd_value[15:0]}};
                ale             = byte_ofs[0];
            end
            ST_W: begin
                data_sram_size  = SIZE_WORD;
                data_sram_wstrb = 4'b1111;
                data_sram_wdata = es_inst.rkd_value;
                ale             = |byte_ofs;
            end
            default: begin
                // non-memory op, defaults hold
            end
        endcase
    end

endmodule

// ==== hdl/mem_req_ctrl.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module mem_req_ctrl (
    input  logic                 es_valid,
    input  pipe_pkg::ds_to_es_t  es_inst,
    input  logic [`XLEN-1:0]     vaddr,
    input  pipe_pkg::mem_exc_t   page_exc,
    input  logic                 ale,
    input  logic                 ms_has_int,
    input  logic                 ms_allow_in,
    input  logic                 data_sram_addr_ok,
    output logic                 data_sram_req,
    output logic                 ready_go,
    output pipe_pkg::es_to_ms_t  es_to_ms_bus
);
    import pipe_pkg::*;

    mem_exc_t exc;
    logic     is_mem;
    logic     own_exc;  // anything that stops this item from touching memory

    always_comb begin
        exc     = page_exc;
        exc.ale = ale;
    end

    assign is_mem  = is_load(es_inst.mem_op) | is_store(es_inst.mem_op);
    assign own_exc = (|exc) | es_inst.prior_exc;

    // request only while memory stage can take the item, so addr_ok and
    // allow-in line up on the accepting edge
    assign data_sram_req = es_valid & is_mem & ~own_exc & ~ms_has_int & ms_allow_in;

    // faulting and non-memory items finish at once
    assign ready_go = own_exc | ~is_mem | (data_sram_req & data_sram_addr_ok);

    always_comb begin
        es_to_ms_bus.pc        = es_inst.pc;
        es_to_ms_bus.dest      = es_inst.dest;
        es_to_ms_bus.gr_we     = es_inst.gr_we & ~own_exc;  // no writeback on a fault
        es_to_ms_bus.mem_op    = es_inst.mem_op;
        es_to_ms_bus.vaddr     = vaddr;
        es_to_ms_bus.exc       = exc;
        es_to_ms_bus.prior_exc = es_inst.prior_exc;
    end

endmodule

// ==== hdl/ex_mem_stage.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_mem_stage (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 wb_ex,
    input  logic                 ms_has_int,

    input  logic                 ds_to_es_valid,
    input  pipe_pkg::ds_to_es_t  ds_to_es_bus,
    output logic                 es_allow_in,

    output logic                 es_to_ms_valid,
    output pipe_pkg::es_to_ms_t  es_to_ms_bus,
    input  logic                 ms_allow_in,

    input  mmu_pkg::crmd_t       csr_crmd,
    input  mmu_pkg::dmw_t        dmw0,
    input  mmu_pkg::dmw_t        dmw1,
    input  logic [`ASID_W-1:0]   tlb_asid,

    output mmu_pkg::tlb_req_t    tlb_req,
    input  mmu_pkg::tlb_resp_t   tlb_resp,

    output logic                 data_sram_req,
    output logic                 data_sram_wr,
    output logic [1:0]           data_sram_size,
    output logic [3:0]           data_sram_wstrb,
    output logic [`XLEN-1:0]     data_sram_addr,
    output logic [`XLEN-1:0]     data_sram_wdata,
    input  logic                 data_sram_addr_ok
);
    import pipe_pkg::*;

    logic             es_valid;
    logic             ready_go;
    ds_to_es_t        es_inst;
    logic [`XLEN-1:0] vaddr;
    mem_exc_t         page_exc;
    logic             ale;

    ex_pipe_reg ex_pipe_reg_inst (
        .clk            (clk),
        .reset          (reset),
        .wb_ex          (wb_ex),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ready_go       (ready_go),
        .ms_allow_in    (ms_allow_in),
        .es_valid       (es_valid),
        .es_allow_in    (es_allow_in),
        .es_to_ms_valid (es_to_ms_valid),
        .es_inst        (es_inst)
    );

    addr_translate addr_translate_inst (
        .es_inst  (es_inst),
        .csr_crmd (csr_crmd),
        .dmw0     (dmw0),
        .dmw1     (dmw1),
        .tlb_asid (tlb_asid),
        .tlb_resp (tlb_resp),
        .vaddr    (vaddr),
        .paddr    (data_sram_addr),  // physical address goes straight to the port
        .tlb_req  (tlb_req),
        .page_exc (page_exc)
    );

    mem_access_format mem_access_format_inst (
        .es_inst         (es_inst),
        .vaddr           (vaddr),
        .data_sram_wr    (data_sram_wr),
        .data_sram_size  (data_sram_size),
        .data_sram_wstrb (data_sram_wstrb),
        .data_sram_wdata (data_sram_wdata),
        .ale             (ale)
    );

    mem_req_ctrl mem_req_ctrl_inst (
        .es_valid          (es_valid),
        .es_inst           (es_inst),
        .vaddr             (vaddr),
        .page_exc          (page_exc),
        .ale               (ale),
        .ms_has_int        (ms_has_int),
        .ms_allow_in       (ms_allow_in),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram_req     (data_sram_req),
        .ready_go          (ready_go),
        .es_to_ms_bus      (es_to_ms_bus)
    );

endmodule

// ==== test/ex_model.svh ====
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// what the stage should do with one captured item
typedef struct packed {
    es_to_ms_t        bus;
    logic             mem;    // memory op with no fault, so it must request
    logic             wr;
    logic [1:0]       size;
    logic [3:0]       wstrb;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
} expect_t;

expect_t expect_q[$];  // items held by the stage, oldest first

function automatic logic window_hit(dmw_t w, logic [`XLEN-1:0] va);
    logic lvl_ok;
    lvl_ok = (csr_crmd.plv == 2'd0 && w.plv0) || (csr_crmd.plv == 2'd3 && w.plv3);
    return lvl_ok && (w.mat == csr_crmd.datm) && (w.vseg == va[`XLEN-1:`SEG_LSB]);
endfunction

function automatic expect_t predict(ds_to_es_t it);
    expect_t          e;
    mem_exc_t         x;
    tlb_resp_t        pte;
    logic [`XLEN-1:0] va;
    logic             ld;
    logic             st;
    logic             walk;
    va   = it.rj_value + it.imm;
    ld   = it.mem_op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W};
    st   = it.mem_op inside {ST_B, ST_H, ST_W};
    pte  = tlb_tab[va[14:12]];  // same entry the responder picks
    e    = '0;
    x    = '0;
    walk = 1'b0;
    // byte accesses keep size 0
    if (it.mem_op inside {LD_H, LD_HU, ST_H}) begin
        e.size = 2'd1;
        x.ale  = va[0];
    end else if (it.mem_op inside {LD_W, ST_W}) begin
        e.size = 2'd2;
        x.ale  = va[1:0] != 2'b00;
    end
    if (it.mem_op == ST_B) begin
        e.wstrb[va[1:0]] = 1'b1;
        e.wdata          = {4{it.rkd_value[7:0]}};
    end else if (it.mem_op == ST_H) begin
        e.wstrb = va[1] ? 4'b1100 : 4'b0011;
        e.wdata = {2{it.rkd_value[15:0]}};
    end else if (it.mem_op == ST_W) begin
        e.wstrb = 4'b1111;
        e.wdata = it.rkd_value;
    end
    if (csr_crmd.da && !csr_crmd.pg) begin
        e.addr = va;
    end else if (!csr_crmd.da && csr_crmd.pg) begin
        walk   = !window_hit(dmw0, va) && !window_hit(dmw1, va) && (ld || st);
        e.addr = window_hit(dmw0, va) ? {dmw0.pseg, va[`SEG_LSB-1:0]}
               : window_hit(dmw1, va) ? {dmw1.pseg, va[`SEG_LSB-1:0]}
               : {pte.ppn, va[`PAGE_OFS_W-1:0]};
    end
    if (walk) begin
        x.tlb_refill    = !pte.found;
        x.load_invalid  = ld && pte.found && !pte.v;
        x.store_invalid = st && pte.found && !pte.v;
        x.plv_invalid   = pte.found && pte.v && (csr_crmd.plv > pte.plv);
        x.store_dirty   = st && pte.found && pte.v && !pte.d && (csr_crmd.plv <= pte.plv);
    end
    e.wr  = st;
    e.mem = (ld || st) && !(|x) && !it.prior_exc;
    e.bus = '{pc: it.pc, dest: it.dest, gr_we: it.gr_we && !(|x) && !it.prior_exc,
              mem_op: it.mem_op, vaddr: va, exc: x, prior_exc: it.prior_exc};
    return e;
endfunction

`endif

// ==== test/tb_ex_mem_stage.sv ====
`timescale 1ns/1ps
`include "ex_consts.svh"

module tb_ex_mem_stage;
    import pipe_pkg::*;
    import mmu_pkg::*;

    localparam int N_TESTS = 6;
    localparam int N_ITEMS = 64;
    localparam int PERIOD  = 40;

    logic               clk = 1'b0;
    logic               reset;
    logic               wb_ex;
    logic               ms_has_int;
    logic               ds_to_es_valid;
    ds_to_es_t          ds_to_es_bus;
    logic               es_allow_in;
    logic               es_to_ms_valid;
    es_to_ms_t          es_to_ms_bus;
    logic               ms_allow_in;
    crmd_t              csr_crmd;
    dmw_t               dmw0;
    dmw_t               dmw1;
    logic [`ASID_W-1:0] tlb_asid;
    tlb_req_t           tlb_req;
    tlb_resp_t          tlb_resp;
    logic               data_sram_req;
    logic               data_sram_wr;
    logic [1:0]         data_sram_size;
    logic [3:0]         data_sram_wstrb;
    logic [`XLEN-1:0]   data_sram_addr;
    logic [`XLEN-1:0]   data_sram_wdata;
    logic               data_sram_addr_ok;

    tlb_resp_t   tlb_tab [0:7];  // indexed by va[14:12]
    logic [31:0] rng = 32'h13eb;
    logic        align_addr;
    logic        seg_pick;       // aim rj at the window segments
    int          allow_pct;
    int          ok_pct;
    int          int_pct;
    int          flush_pct;
    int          errors = 0;
    int          err_mark;
    int          tests_failed = 0;
    int          sent;
    int          left;
    int          flushed;
    int          faulted;

    `include "ex_model.svh"

    ex_mem_stage ex_mem_stage_inst (.*);

    always #(PERIOD / 2) clk = ~clk;

    always_comb begin
        tlb_resp = tlb_tab[{tlb_req.vppn[1:0], tlb_req.va_bit12}];  // same-cycle answer
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic chance(input int pct);
        return int'(next_rand() % 32'd100) < pct;
    endfunction

    // kind 0 never usable, 1 usable at the current level, 2 fully random
    function automatic dmw_t make_window(input int kind);
        dmw_t w;
        w = dmw_t'(10'(next_rand()));
        if (kind == 0) begin
            w.plv0 = 1'b0;
            w.plv3 = 1'b0;
        end else if (kind == 1) begin
            w.mat  = csr_crmd.datm;
            w.plv0 = w.plv0 | (csr_crmd.plv == 2'd0);
            w.plv3 = w.plv3 | (csr_crmd.plv == 2'd3);
        end
        return w;
    endfunction

    task automatic fill_table(input logic usable);
        for (int i = 0; i < 8; i++) begin
            // usable entries are present, valid, dirty and open to every level
            tlb_tab[i] = tlb_resp_t'(25'(next_rand()) | (usable ? 25'h100_000f : 25'h0));
        end
    endtask

    function automatic ds_to_es_t make_item();
        ds_to_es_t   it;
        logic [31:0] va;
        logic [2:0]  seg;
        it.pc        = next_rand() & 32'hffff_fffc;
        it.rj_value  = next_rand();
        it.rkd_value = next_rand();
        it.imm       = next_rand() & 32'h0000_0fff;
        it.dest      = 5'(next_rand());
        it.gr_we     = 1'(next_rand());
        it.mem_op    = mem_op_e'(4'(next_rand() % 32'd9));
        it.prior_exc = chance(6);
        if (seg_pick) begin
            seg         = chance(33) ? dmw0.vseg : chance(50) ? dmw1.vseg : 3'(next_rand());
            it.rj_value = {seg, 1'b0, it.rj_value[27:0]};  // bit 28 clear so imm cannot carry
        end
        if (align_addr) begin
            va     = it.rj_value + it.imm;
            it.imm = it.imm - {30'd0, va[1:0]};
        end
        return it;
    endfunction

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        $display("FAIL %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic check_cycle();
        expect_t  e;
        tlb_req_t exp_tlb;
        logic     busy;
        logic     exp_req;
        logic     exp_ready;
        logic     exp_allow;
        busy      = expect_q.size() > 0;
        e         = busy ? expect_q[0] : '0;
        exp_req   = busy && e.mem && !ms_has_int && ms_allow_in;
        exp_ready = busy && (!e.mem || (exp_req && data_sram_addr_ok));
        exp_allow = !busy || (exp_ready && ms_allow_in);
        exp_tlb   = '{vppn: e.bus.vaddr[31:13], va_bit12: e.bus.vaddr[12], asid: tlb_asid};
        if (data_sram_req !== exp_req) begin
            value_error("data_sram_req", 128'(data_sram_req), 128'(exp_req));
        end
        if (es_to_ms_valid !== (exp_ready && !wb_ex)) begin
            value_error("es_to_ms_valid", 128'(es_to_ms_valid), 128'(exp_ready && !wb_ex));
        end
        if (es_allow_in !== exp_allow) begin
            value_error("es_allow_in", 128'(es_allow_in), 128'(exp_allow));
        end
        if (busy && tlb_req !== exp_tlb) begin
            value_error("tlb_req", 128'(tlb_req), 128'(exp_tlb));
        end
        if (exp_req) begin
            if (data_sram_addr !== e.addr) begin
                value_error("data_sram_addr", 128'(data_sram_addr), 128'(e.addr));
            end
            if (data_sram_wr !== e.wr) begin
                value_error("data_sram_wr", 128'(data_sram_wr), 128'(e.wr));
            end
            if (data_sram_size !== e.size) begin
                value_error("data_sram_size", 128'(data_sram_size), 128'(e.size));
            end
            if (data_sram_wstrb !== e.wstrb) begin
                value_error("data_sram_wstrb", 128'(data_sram_wstrb), 128'(e.wstrb));
            end
            if (e.wr && data_sram_wdata !== e.wdata) begin
                value_error("data_sram_wdata", 128'(data_sram_wdata), 128'(e.wdata));
            end
        end
        if (busy && es_to_ms_valid && es_to_ms_bus !== e.bus) begin
            value_error("es_to_ms_bus", 128'(es_to_ms_bus), 128'(e.bus));
        end
        if (es_to_ms_valid && ms_allow_in) begin
            left++;  // handshake seen at the DUT
        end
        if (busy && wb_ex) begin
            void'(expect_q.pop_front());  // flushed item never reaches memory stage
            flushed++;
        end else if (exp_ready && ms_allow_in) begin
            void'(expect_q.pop_front());
        end
    endtask

    task automatic run_items(input int n);
        ds_to_es_t offer;
        logic      pending;
        offer   = '0;
        pending = 1'b0;
        while (n > 0 || pending || expect_q.size() > 0) begin
            @(negedge clk);
            if (!pending && n > 0) begin
                offer   = make_item();
                pending = 1'b1;
                n--;
            end
            ms_allow_in       = chance(allow_pct);
            data_sram_addr_ok = chance(ok_pct);
            ms_has_int        = chance(int_pct);
            wb_ex             = chance(flush_pct);
            ds_to_es_valid    = pending && chance(80);
            ds_to_es_bus      = offer;
            #(PERIOD / 4);
            check_cycle();
            if (ds_to_es_valid && es_allow_in) begin
                pending = 1'b0;
                sent++;
                if (wb_ex) begin
                    flushed++;  // taken on the flushing edge, dropped at once
                end else begin
                    expect_q.push_back(predict(offer));
                    if (expect_q[$].bus.exc != '0 || offer.prior_exc) faulted++;
                end
            end
        end
        @(negedge clk);
        ds_to_es_valid = 1'b0;
        wb_ex          = 1'b0;
        ms_has_int     = 1'b0;
    endtask

    task automatic setup(input logic align, input logic segs, input int allow, input int ok,
                         input int intr, input int flush);
        align_addr = align;
        seg_pick   = segs;
        allow_pct  = allow;
        ok_pct     = ok;
        int_pct    = intr;
        flush_pct  = flush;
        err_mark   = errors;
        sent       = 0;
        left       = 0;
        flushed    = 0;
        faulted    = 0;
        csr_crmd   = '{da: 1'b1, pg: 1'b0, plv: 2'(next_rand()), datm: 2'(next_rand())};
    endtask

    task automatic end_test(input int num, input string name);
        if (sent != left + flushed) begin
            $display("items lost or duplicated: %0d sent, %0d left, %0d flushed",
                     sent, left, flushed);
            errors++;
        end
        if (errors == err_mark) begin
            $display("test %0d %s: ok, %0d items, %0d faulting, %0d flushed",
                     num, name, sent, faulted, flushed);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
            tests_failed++;
        end
    endtask

    initial begin
        reset             = 1'b1;
        wb_ex             = 1'b0;
        ms_has_int        = 1'b0;
        ds_to_es_valid    = 1'b0;
        ds_to_es_bus      = '0;
        ms_allow_in       = 1'b0;
        csr_crmd          = '0;
        dmw0              = '0;
        dmw1              = '0;
        tlb_asid          = 10'(next_rand());
        data_sram_addr_ok = 1'b0;
        fill_table(1'b1);
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(PERIOD / 4);
        if (es_to_ms_valid !== 1'b0 || data_sram_req !== 1'b0 || es_allow_in !== 1'b1) begin
            $display("stage not idle after reset");
            errors++;
        end

        setup(1'b1, 1'b0, 75, 75, 0, 0);
        run_items(N_ITEMS);
        end_test(1, "direct mode");

        setup(1'b1, 1'b1, 75, 75, 0, 0);
        for (int k = 0; k < 4; k++) begin
            // window 0 only, window 1 only, both on one segment, random windows
            csr_crmd = '{da: 1'b0, pg: 1'b1, plv: chance(50) ? 2'd0 : 2'd3, datm: 2'(next_rand())};
            dmw0     = make_window(k == 1 ? 0 : (k == 3 ? 2 : 1));
            dmw1     = make_window(k == 0 ? 0 : (k == 3 ? 2 : 1));
            if (k == 2) dmw1.vseg = dmw0.vseg;
            fill_table(1'b1);
            run_items(N_ITEMS / 4);
        end
        end_test(2, "window mapping");

        setup(1'b1, 1'b0, 75, 75, 0, 0);
        for (int k = 0; k < 4; k++) begin
            csr_crmd = '{da: 1'b0, pg: 1'b1, plv: 2'(next_rand()), datm: 2'(next_rand())};
            dmw0     = make_window(0);
            dmw1     = make_window(0);
            fill_table(1'b0);
            run_items(N_ITEMS / 4);
        end
        end_test(3, "page exceptions");

        setup(1'b0, 1'b0, 75, 75, 0, 0);
        run_items(N_ITEMS);
        end_test(4, "misalignment");

        setup(1'b0, 1'b0, 35, 35, 0, 0);
        run_items(N_ITEMS);
        end_test(5, "back-pressure");

        setup(1'b0, 1'b0, 70, 70, 40, 6);
        run_items(N_ITEMS);
        end_test(6, "flush and blocking");

        $display("%0d tests ok, %0d tests with errors", N_TESTS - tests_failed, tests_failed);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // every item gets at most 64 cycles
    initial begin
        #(N_TESTS * N_ITEMS * 64 * PERIOD);
        $display("timeout: the stage stopped making progress");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
+incdir+test
hdl/pipe_pkg.sv
hdl/mmu_pkg.sv
hdl/ex_pipe_reg.sv
hdl/addr_translate.sv
hdl/mem_access_format.sv
hdl/mem_req_ctrl.sv
hdl/ex_mem_stage.sv
test/tb_ex_mem_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_ex_mem_stage -Mdir obj_dir \
    > build.log 2>&1 &&
./obj_dir/Vtb_ex_mem_stage > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; } ||
echo "simulation passed"
